// ==== source/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

  // ==============================
  // sizing shared by RTL and bench
  // ==============================

  // bit period scaler width, one bit lasts scaler+1 clocks
  localparam int SCALER_W = 16;

  // default transmit FIFO depth, power of two
  localparam int FIFO_DEPTH_DEF = 8;

endpackage : uart_cfg_pkg

// ==== source/uart_frame_pkg.sv ====
package uart_frame_pkg;

  // ==============================
  // frame format
  // ==============================

  // data bits per frame, sent LSB first
  localparam int DATA_BITS = 8;

  // parity mode, sampled at frame start
  typedef enum logic [1:0] {
    PAR_NONE = 2'd0,
    PAR_EVEN = 2'd1,
    PAR_ODD  = 2'd2
  } parity_e;

  // ==============================
  // transmitter sequencing
  // ==============================

  // frame phases, also the line selector for the shifter
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_START  = 3'd1,
    ST_DATA   = 3'd2,
    ST_PARITY = 3'd3,
    ST_STOP   = 3'd4
  } tx_state_e;

endpackage : uart_frame_pkg

// ==== source/uart_tx_fifo.sv ====
`timescale 1ns/1ns

module uart_tx_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_push,
  input  logic [7:0] i_push_data,
  input  logic       i_pop,
  output logic [7:0] o_head,
  output logic       o_empty,
  output logic       o_full,
  output logic       o_overflow
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);
  localparam logic [ADDR_W:0] FULL_CNT = FIFO_DEPTH[ADDR_W:0];

  logic [7:0]        mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   count;
  logic              push_ok;
  logic              pop_ok;

  // a push into a full buffer is lost, even when a pop is under way
  assign push_ok = i_push && !o_full;
  assign pop_ok  = i_pop && !o_empty;

  assign o_empty = (count == '0);
  assign o_full  = (count == FULL_CNT);
  assign o_head  = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  // pointers, occupancy and drop flag
  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_overflow <= 1'b0;
    end else begin
      o_overflow <= i_push && o_full;
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : uart_tx_fifo

// ==== source/uart_baud_timer.sv ====
`timescale 1ns/1ns

module uart_baud_timer #(
  parameter int SCALER_W = 16
) (
  input  logic                clk,
  input  logic                i_reset,
  input  logic                i_start,
  input  logic                i_run,
  input  logic [SCALER_W-1:0] i_scaler,
  output logic                o_tick
);

  logic [SCALER_W-1:0] scaler_q;
  logic [SCALER_W-1:0] count;

  // last cycle of the bit period
  assign o_tick = i_run && (count == '0);

  // scaler held for the whole frame
  always_ff @(posedge clk) begin
    if (i_start) begin
      scaler_q <= i_scaler;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      count <= '0;
    end else if (i_start) begin
      // start wins over a stop tick on back to back frames
      count <= i_scaler;
    end else if (i_run) begin
      if (count == '0) begin
        count <= scaler_q;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

endmodule : uart_baud_timer

// ==== source/uart_tx_shifter.sv ====
`timescale 1ns/1ns

module uart_tx_shifter (
  input  logic                      clk,
  input  logic                      i_reset,
  input  logic                      i_load,
  input  logic [7:0]                i_data,
  input  uart_frame_pkg::parity_e   i_parity_mode,
  input  logic                      i_shift,
  input  uart_frame_pkg::tx_state_e i_phase,
  output logic                      o_txd,
  output logic                      o_parity_en
);

  logic [uart_frame_pkg::DATA_BITS-1:0] shreg;
  logic                                 parity_bit;
  logic                                 line_next;

  // ==============================
  // frame capture
  // ==============================

  always_ff @(posedge clk) begin
    if (i_load) begin
      shreg      <= i_data;
      // even parity is the plain xor, odd is its inverse
      parity_bit <= (^i_data) ^ (i_parity_mode == uart_frame_pkg::PAR_ODD);
    end else if (i_shift) begin
      shreg <= shreg >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_parity_en <= 1'b0;
    end else if (i_load) begin
      o_parity_en <= (i_parity_mode != uart_frame_pkg::PAR_NONE);
    end
  end

  // ==============================
  // line level
  // ==============================

  // phase is the one about to begin, so a shift on this edge
  // means the next data bit is already at index 1
  always_comb begin
    unique case (i_phase)
      uart_frame_pkg::ST_START:  line_next = 1'b0;
      uart_frame_pkg::ST_DATA:   line_next = i_shift ? shreg[1] : shreg[0];
      uart_frame_pkg::ST_PARITY: line_next = parity_bit;
      default:                   line_next = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_txd <= 1'b1;
    end else begin
      o_txd <= line_next;
    end
  end

endmodule : uart_tx_shifter

// ==== source/uart_tx_fsm.sv ====
`timescale 1ns/1ns

module uart_tx_fsm (
  input  logic                      clk,
  input  logic                      i_reset,
  input  logic                      i_fifo_empty,
  input  logic                      i_tick,
  input  logic                      i_parity_en,
  output logic                      o_pop,
  output logic                      o_load,
  output logic                      o_timer_start,
  output logic                      o_timer_run,
  output logic                      o_shift,
  output uart_frame_pkg::tx_state_e o_phase,
  output logic                      o_active
);

  localparam int CNT_W = $clog2(uart_frame_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(uart_frame_pkg::DATA_BITS - 1);

  uart_frame_pkg::tx_state_e state;
  uart_frame_pkg::tx_state_e state_next;
  logic [CNT_W-1:0]          bit_cnt;
  logic                      frame_start;

  // ==============================
  // frame launch
  // ==============================

  // from idle, or straight out of a stop bit with no gap
  assign frame_start = !i_fifo_empty &&
                       ((state == uart_frame_pkg::ST_IDLE) ||
                        (state == uart_frame_pkg::ST_STOP && i_tick));

  assign o_pop         = frame_start;
  assign o_load        = frame_start;
  assign o_timer_start = frame_start;
  assign o_timer_run   = (state != uart_frame_pkg::ST_IDLE);
  assign o_active      = (state != uart_frame_pkg::ST_IDLE);
  assign o_shift       = (state == uart_frame_pkg::ST_DATA) && i_tick;

  // shifter registers the line for the coming phase
  assign o_phase = state_next;

  // ==============================
  // next state
  // ==============================

  always_comb begin
    state_next = state;
    unique case (state)
      uart_frame_pkg::ST_IDLE: begin
        if (frame_start) begin
          state_next = uart_frame_pkg::ST_START;
        end
      end
      uart_frame_pkg::ST_START: begin
        if (i_tick) begin
          state_next = uart_frame_pkg::ST_DATA;
        end
      end
      uart_frame_pkg::ST_DATA: begin
        if (i_tick && bit_cnt == LAST_BIT) begin
          state_next = i_parity_en ? uart_frame_pkg::ST_PARITY
                                   : uart_frame_pkg::ST_STOP;
        end
      end
      uart_frame_pkg::ST_PARITY: begin
        if (i_tick) begin
          state_next = uart_frame_pkg::ST_STOP;
        end
      end
      uart_frame_pkg::ST_STOP: begin
        if (frame_start) begin
          state_next = uart_frame_pkg::ST_START;
        end else if (i_tick) begin
          state_next = uart_frame_pkg::ST_IDLE;
        end
      end
      default: state_next = uart_frame_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state   <= uart_frame_pkg::ST_IDLE;
      bit_cnt <= '0;
    end else begin
      state <= state_next;
      // data bit index, cleared whenever outside the data phase
      if (state != uart_frame_pkg::ST_DATA) begin
        bit_cnt <= '0;
      end else if (i_tick) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule : uart_tx_fsm

// ==== source/uart_console_top.sv ====
`timescale 1ns/1ns

module uart_console_top #(
  parameter int FIFO_DEPTH = uart_cfg_pkg::FIFO_DEPTH_DEF,
  parameter int SCALER_W   = uart_cfg_pkg::SCALER_W
) (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_wr_stb,
  input  logic [7:0]              i_wr_data,
  input  logic [SCALER_W-1:0]     i_scaler,
  input  uart_frame_pkg::parity_e i_parity_mode,
  output logic                    o_txd,
  output logic                    o_busy,
  output logic                    o_overflow
);

  logic                      fifo_empty;
  logic [7:0]                fifo_head;
  logic                      pop;
  logic                      load;
  logic                      timer_start;
  logic                      timer_run;
  logic                      tick;
  logic                      shift;
  logic                      parity_en;
  logic                      active;
  uart_frame_pkg::tx_state_e phase;

  // busy until the queue drains and the last stop bit is out
  assign o_busy = !fifo_empty || active;

  // ==============================
  // byte queue
  // ==============================

  // full flag only feeds the drop logic inside the FIFO
  uart_tx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_push      (i_wr_stb),
    .i_push_data (i_wr_data),
    .i_pop       (pop),
    .o_head      (fifo_head),
    .o_empty     (fifo_empty),
    .o_full      (),
    .o_overflow  (o_overflow)
  );

  // ==============================
  // bit timing and sequencing
  // ==============================

  uart_baud_timer #(
    .SCALER_W (SCALER_W)
  ) u_timer (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_start  (timer_start),
    .i_run    (timer_run),
    .i_scaler (i_scaler),
    .o_tick   (tick)
  );

  uart_tx_fsm u_fsm (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_fifo_empty  (fifo_empty),
    .i_tick        (tick),
    .i_parity_en   (parity_en),
    .o_pop         (pop),
    .o_load        (load),
    .o_timer_start (timer_start),
    .o_timer_run   (timer_run),
    .o_shift       (shift),
    .o_phase       (phase),
    .o_active      (active)
  );

  uart_tx_shifter u_shifter (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_load        (load),
    .i_data        (fifo_head),
    .i_parity_mode (i_parity_mode),
    .i_shift       (shift),
    .i_phase       (phase),
    .o_txd         (o_txd),
    .o_parity_en   (parity_en)
  );

endmodule : uart_console_top

// ==== sim/uart_console_chk.sv ====
`timescale 1ns/1ns

module uart_console_chk (
  input logic                      clk,
  input logic                      i_reset,
  input logic                      i_wr_stb,
  input logic                      i_txd,
  input logic                      i_busy,
  input logic                      i_overflow,
  input uart_frame_pkg::tx_state_e i_state
);

  int fail_count = 0;

  // one drop pulse per rejected write, none without a write
  a_overflow_pulse: assert property (@(posedge clk) disable iff (i_reset)
    !i_wr_stb |=> !i_overflow)
    else begin
      fail_count++;
      $error("o_overflow high without a write in the cycle before");
    end

  // line idles high whenever nothing is queued or in flight
  a_idle_line_high: assert property (@(posedge clk) disable iff (i_reset)
    !i_busy |-> i_txd)
    else begin
      fail_count++;
      $error("o_txd low while o_busy is low");
    end

  a_state_legal: assert property (@(posedge clk) disable iff (i_reset)
    i_state inside {uart_frame_pkg::ST_IDLE, uart_frame_pkg::ST_START,
                    uart_frame_pkg::ST_DATA, uart_frame_pkg::ST_PARITY,
                    uart_frame_pkg::ST_STOP})
    else begin
      fail_count++;
      $error("transmitter state outside the legal range");
    end

  // first reset cycle still carries the power-up contents
  a_reset_quiet: assert property (@(posedge clk)
    i_reset && $past(i_reset) |-> !i_busy)
    else begin
      fail_count++;
      $error("o_busy high during reset");
    end

endmodule : uart_console_chk

// ==== sim/uart_rx_monitor.sv ====
`timescale 1ns/1ns

module uart_rx_monitor #(
  parameter int SCALER_W = 16
) (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_wr_stb,
  input  logic                    i_txd,
  input  logic                    i_busy,
  input  logic                    i_overflow,
  input  logic [SCALER_W-1:0]     i_scaler,
  input  uart_frame_pkg::parity_e i_parity_mode,
  output int                      o_data_errs,
  output int                      o_frame_errs,
  output int                      o_ovf_errs,
  output int                      o_unexpected,
  output int                      o_frames
);

  logic [7:0] exp_q [$];
  int         ovf_row = 0;
  logic       seen_stb = 1'b0;

  task push_expected(input logic [7:0] b);
    exp_q.push_back(b);
  endtask

  // ==============================
  // end of row bookkeeping
  // ==============================

  task check_row_end(input int exp_ovf);
    if (ovf_row != exp_ovf) begin
      $display("Mismatch at %0t: o_overflow pulses expected %0d got %0d",
               $time, exp_ovf, ovf_row);
      o_ovf_errs++;
    end
    if (exp_q.size() != 0) begin
      $display("at %0t, %0d expected bytes were never received", $time, exp_q.size());
      o_frame_errs += exp_q.size();
      exp_q.delete();
    end
    ovf_row = 0;
  endtask

  // quiet line before the first strobe, and drop pulse count
  always @(negedge clk) begin
    if (i_reset) begin
      seen_stb = 1'b0;
    end else begin
      if (i_wr_stb) begin
        seen_stb = 1'b1;
      end else if (!seen_stb && (i_txd !== 1'b1 || i_busy !== 1'b0 || i_overflow !== 1'b0)) begin
        $display("at %0t, outputs left their idle levels before any write", $time);
        o_frame_errs++;
      end
      if (i_overflow === 1'b1) begin
        ovf_row++;
      end
    end
  end

  // ==============================
  // frame decoder
  // ==============================

  initial begin : rx
    int         bit_len;
    int         mid;
    int         n_bits;
    int         ones;
    logic       v;
    logic       par;
    logic       framing_bad;
    logic       chained;
    logic       exp_par;
    logic [7:0] data;
    logic [7:0] exp_b;
    chained = 1'b0;
    forever begin
      if (!chained) begin
        do @(negedge clk); while (i_reset || i_txd !== 1'b0);
      end
      bit_len     = int'(i_scaler) + 1;
      mid         = bit_len / 2;
      n_bits      = (i_parity_mode != uart_frame_pkg::PAR_NONE) ? 11 : 10;
      framing_bad = 1'b0;
      data        = '0;
      par         = 1'b0;
      // every cycle of start and stop is checked, which pins the bit width
      for (int b = 0; b < n_bits; b++) begin
        for (int c = 0; c < bit_len; c++) begin
          if (b != 0 || c != 0) begin
            @(negedge clk);
          end
          v = i_txd;
          if (b == 0 && v !== 1'b0) framing_bad = 1'b1;
          if (b == n_bits - 1 && v !== 1'b1) framing_bad = 1'b1;
          if (c == mid) begin
            if (b >= 1 && b <= uart_frame_pkg::DATA_BITS) data[b-1] = v;
            if (b == 9 && n_bits == 11) par = v;
          end
        end
      end
      // first cycle after the stop bit, low means the next start
      @(negedge clk);
      chained = (i_txd === 1'b0);
      o_frames++;
      if (framing_bad) begin
        $display("at %0t, start or stop bit at the wrong level or width", $time);
        o_frame_errs++;
      end
      if (exp_q.size() == 0) begin
        $display("at %0t, unexpected frame with data %02h", $time, data);
        o_unexpected++;
      end else begin
        exp_b = exp_q.pop_front();
        if (data !== exp_b) begin
          $display("Mismatch at %0t: rx_data expected %02h got %02h", $time, exp_b, data);
          o_data_errs++;
        end
        if (n_bits == 11) begin
          ones    = $countones(exp_b);
          // even parity makes the count of ones over data and parity even
          exp_par = (i_parity_mode == uart_frame_pkg::PAR_EVEN) ? (ones % 2 == 1)
                                                                 : (ones % 2 == 0);
          if (par !== exp_par) begin
            $display("Mismatch at %0t: rx_parity expected %0b got %0b",
                     $time, exp_par, par);
            o_data_errs++;
          end
        end
      end
      if (!chained && exp_q.size() != 0) begin
        $display("at %0t, idle gap between queued frames", $time);
        o_frame_errs++;
      end
    end
  end

endmodule : uart_rx_monitor

// ==== sim/uart_console_tb.sv ====
`timescale 1ns/1ns

module uart_console_tb;

  localparam int SCALER_W = uart_cfg_pkg::SCALER_W;
  localparam int DEPTH    = uart_cfg_pkg::FIFO_DEPTH_DEF;
  localparam int N_ROWS   = 7;
  localparam int MARGIN   = 500;

  // ==============================
  // stimulus table
  // ==============================

  // scaler, parity, burst length, random data, base for fixed data
  int row_scaler [N_ROWS] = '{3, 7, 20, 3, 5, 6, 4};
  uart_frame_pkg::parity_e row_par [N_ROWS] = '{
    uart_frame_pkg::PAR_NONE, uart_frame_pkg::PAR_NONE, uart_frame_pkg::PAR_NONE,
    uart_frame_pkg::PAR_NONE, uart_frame_pkg::PAR_EVEN, uart_frame_pkg::PAR_ODD,
    uart_frame_pkg::PAR_EVEN};
  int         row_burst [N_ROWS] = '{4, 3, 2, 5, 4, 4, DEPTH + 4};
  bit         row_rand  [N_ROWS] = '{0, 1, 0, 1, 1, 1, 1};
  logic [7:0] row_base  [N_ROWS] = '{8'h41, 8'h00, 8'ha5, 8'h00, 8'h00, 8'h00, 8'h00};

  logic                    clk = 1'b0;
  logic                    i_reset;
  logic                    i_wr_stb;
  logic [7:0]              i_wr_data;
  logic [SCALER_W-1:0]     i_scaler;
  uart_frame_pkg::parity_e i_parity_mode;
  logic                    o_txd;
  logic                    o_busy;
  logic                    o_overflow;
  int data_errs;
  int frame_errs;
  int ovf_errs;
  int unexpected;
  int frames;
  int cycles = 0;
  int limit  = 0;
  logic [15:0] lfsr_state = 16'd27;

  always #2 clk = ~clk;

  uart_console_top #(
    .FIFO_DEPTH (DEPTH),
    .SCALER_W   (SCALER_W)
  ) i_dut (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_wr_stb      (i_wr_stb),
    .i_wr_data     (i_wr_data),
    .i_scaler      (i_scaler),
    .i_parity_mode (i_parity_mode),
    .o_txd         (o_txd),
    .o_busy        (o_busy),
    .o_overflow    (o_overflow)
  );

  uart_rx_monitor #(
    .SCALER_W (SCALER_W)
  ) u_mon (
    .clk (clk), .i_reset (i_reset), .i_wr_stb (i_wr_stb), .i_txd (o_txd),
    .i_busy (o_busy), .i_overflow (o_overflow), .i_scaler (i_scaler),
    .i_parity_mode (i_parity_mode), .o_data_errs (data_errs),
    .o_frame_errs (frame_errs), .o_ovf_errs (ovf_errs),
    .o_unexpected (unexpected), .o_frames (frames)
  );

  bind uart_console_top uart_console_chk u_chk (
    .clk (clk), .i_reset (i_reset), .i_wr_stb (i_wr_stb), .i_txd (o_txd),
    .i_busy (o_busy), .i_overflow (o_overflow), .i_state (u_fsm.state)
  );

  // 16 bit Fibonacci register, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task next_random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  function automatic int timeout_limit();
    int sum;
    sum = 10 + 20 + MARGIN;
    for (int r = 0; r < N_ROWS; r++) begin
      sum += row_burst[r] * 11 * (row_scaler[r] + 1) + 8;
    end
    return sum;
  endfunction

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout, run still going after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // ==============================
  // main sequence
  // ==============================

  initial begin
    int         kept;
    int         total;
    int         assert_errs;
    logic [7:0] b;
    limit         = timeout_limit();
    i_reset       = 1'b1;
    i_wr_stb      = 1'b0;
    i_wr_data     = '0;
    i_scaler      = SCALER_W'(3);
    i_parity_mode = uart_frame_pkg::PAR_NONE;
    repeat (10) @(posedge clk);
    i_reset <= 1'b0;
    // quiet window checked by the monitor
    repeat (20) @(posedge clk);
    for (int r = 0; r < N_ROWS; r++) begin
      i_scaler      <= SCALER_W'(row_scaler[r]);
      i_parity_mode <= row_par[r];
      @(posedge clk);
      // one byte leaves at once, the rest fill the FIFO
      kept = (row_burst[r] > DEPTH + 1) ? DEPTH + 1 : row_burst[r];
      for (int i = 0; i < row_burst[r]; i++) begin
        if (row_rand[r]) begin
          next_random_byte(b);
        end else begin
          b = row_base[r] + 8'(i);
        end
        i_wr_stb  <= 1'b1;
        i_wr_data <= b;
        if (i < kept) begin
          u_mon.push_expected(b);
        end
        @(posedge clk);
      end
      i_wr_stb <= 1'b0;
      do @(negedge clk); while (o_busy === 1'b1);
      repeat (4) @(posedge clk);
      u_mon.check_row_end(row_burst[r] - kept);
    end
    assert_errs = i_dut.u_chk.fail_count;
    total       = data_errs + frame_errs + ovf_errs + unexpected + assert_errs;
    $display("errors: data=%0d framing=%0d overflow=%0d unexpected=%0d assert=%0d (frames=%0d)",
             data_errs, frame_errs, ovf_errs, unexpected, assert_errs, frames);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : uart_console_tb

// ==== filelist.f ====
source/uart_cfg_pkg.sv
source/uart_frame_pkg.sv
source/uart_tx_fifo.sv
source/uart_baud_timer.sv
source/uart_tx_shifter.sv
source/uart_tx_fsm.sv
source/uart_console_top.sv
sim/uart_console_chk.sv
sim/uart_rx_monitor.sv
sim/uart_console_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= uart_console_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
